//--- src/exe_pkg.sv
// shared widths, RV32I opcode and funct codes, ALU and operand select codes for the execute slice
package exe_pkg;

	// datapath and register file geometry
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int ALU_OP_W   = 4;
	localparam int SEL_W      = 4;

	// major opcodes handled by the slice
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	// funct3 codes shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// alu operation codes
	localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'b0000;
	localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'b0001;
	localparam logic [ALU_OP_W-1:0] ALU_SLL   = 4'b0010;
	localparam logic [ALU_OP_W-1:0] ALU_SLT   = 4'b0011;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 4'b0100;
	localparam logic [ALU_OP_W-1:0] ALU_XOR   = 4'b0101;
	localparam logic [ALU_OP_W-1:0] ALU_SRL   = 4'b0110;
	localparam logic [ALU_OP_W-1:0] ALU_SRA   = 4'b0111;
	localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'b1000;
	localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'b1001;
	// copies source 2, used by LUI
	localparam logic [ALU_OP_W-1:0] ALU_PASS2 = 4'b1010;

	// source 1 select, alu_sel[1:0]
	localparam logic [1:0] SEL1_ZERO = 2'b00;
	localparam logic [1:0] SEL1_REG1 = 2'b01;
	localparam logic [1:0] SEL1_PC   = 2'b10;

	// source 2 select, alu_sel[3:2]
	localparam logic [1:0] SEL2_ZERO = 2'b00;
	localparam logic [1:0] SEL2_REG2 = 2'b01;
	localparam logic [1:0] SEL2_IMM  = 2'b10;
	localparam logic [1:0] SEL2_FOUR = 2'b11;

	// one instruction word, seen as R, I or U format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [19:0] imm20;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
	} rv_inst_u;

endpackage

//--- src/inst_decode.sv
// combinational RV32I decoder giving register addresses, immediate, ALU code and operand selects
`timescale 1ns/1ps

module inst_decode import exe_pkg::*; (
	input  rv_inst_u               inst_i,
	output logic [REG_ADDR_W-1:0]  rs1_addr_o,
	output logic [REG_ADDR_W-1:0]  rs2_addr_o,
	output logic [XLEN-1:0]        imm_o,
	output logic [ALU_OP_W-1:0]    alu_op_o,
	output logic [SEL_W-1:0]       alu_sel_o,
	output logic                   wd_o,
	output logic [REG_ADDR_W-1:0]  wreg_o
);

	// funct3 plus alternate bit to alu code
	function automatic logic [ALU_OP_W-1:0] alu_code(input logic [2:0] funct3, input logic alt);
		logic [ALU_OP_W-1:0] code;
		case (funct3)
			F3_ADD:  code = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  code = ALU_SLL;
			F3_SLT:  code = ALU_SLT;
			F3_SLTU: code = ALU_SLTU;
			F3_XOR:  code = ALU_XOR;
			F3_SR:   code = alt ? ALU_SRA : ALU_SRL;
			F3_OR:   code = ALU_OR;
			default: code = ALU_AND;
		endcase
		return code;
	endfunction

	// register fields sit at fixed positions in every format
	assign rs1_addr_o = inst_i.i.rs1;
	assign rs2_addr_o = inst_i.r.rs2;
	assign wreg_o     = inst_i.u.rd;

	always_comb begin
		// defaults describe a no-write instruction
		imm_o     = '0;
		alu_op_o  = ALU_ADD;
		alu_sel_o = {SEL2_ZERO, SEL1_ZERO};
		wd_o      = 1'b0;
		case (inst_i.u.opcode)
			OPC_OP: begin
				// bit 30 picks sub or sra
				alu_op_o  = alu_code(inst_i.r.funct3, inst_i.r.funct7[5]);
				alu_sel_o = {SEL2_REG2, SEL1_REG1};
				wd_o      = 1'b1;
			end
			OPC_OP_IMM: begin
				imm_o     = {{(XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
				// no subi, bit 30 only matters for right shifts
				alu_op_o  = alu_code(inst_i.i.funct3,
					inst_i.i.imm12[10] && (inst_i.i.funct3 == F3_SR));
				alu_sel_o = {SEL2_IMM, SEL1_REG1};
				wd_o      = 1'b1;
			end
			OPC_LUI: begin
				// zero plus upper immediate
				imm_o     = {inst_i.u.imm20, 12'b0};
				alu_op_o  = ALU_PASS2;
				alu_sel_o = {SEL2_IMM, SEL1_ZERO};
				wd_o      = 1'b1;
			end
			OPC_AUIPC: begin
				imm_o     = {inst_i.u.imm20, 12'b0};
				alu_sel_o = {SEL2_IMM, SEL1_PC};
				wd_o      = 1'b1;
			end
			OPC_JAL, OPC_JALR: begin
				// link value only, pc plus four
				alu_sel_o = {SEL2_FOUR, SEL1_PC};
				wd_o      = 1'b1;
			end
			default: begin
				// stores, loads, branches etc write nothing
				wd_o = 1'b0;
			end
		endcase
	end

	// source 1 has only three legal selects
	always_comb begin
		assert (alu_sel_o[1:0] != 2'b11)
			else $error("decode produced unused source 1 select");
	end

endmodule

//--- src/reg_file.sv
// 32 by 32 integer register file, two combinational reads and one synchronous write, x0 fixed at zero
`timescale 1ns/1ps

module reg_file import exe_pkg::*; (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  logic [REG_ADDR_W-1:0]  rs1_addr_i,
	input  logic [REG_ADDR_W-1:0]  rs2_addr_i,
	input  logic                   we_i,
	input  logic [REG_ADDR_W-1:0]  waddr_i,
	input  logic [XLEN-1:0]        wdata_i,
	output logic [XLEN-1:0]        rs1_data_o,
	output logic [XLEN-1:0]        rs2_data_o
);

	logic [XLEN-1:0] regs [NUM_REGS];

	// write port, x0 never written
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int k = 0; k < NUM_REGS; k++) begin
				regs[k] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// read ports, address zero forced to zero
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

	// x0 storage stays clear across all writes
	assert property (@(posedge clk_i) disable iff (reset_i) regs[0] == '0)
		else $error("register x0 holds a nonzero value");

endmodule

//--- src/alu.sv
// combinational integer ALU for the RV32I execute slice, selected by a 4-bit operation code
`timescale 1ns/1ps

module alu import exe_pkg::*; (
	input  logic [XLEN-1:0]      src1_i,
	input  logic [XLEN-1:0]      src2_i,
	input  logic [ALU_OP_W-1:0]  alu_op_i,
	output logic [XLEN-1:0]      result_o
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// only the low five bits shift
	assign shamt       = src2_i[4:0];
	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	always_comb begin
		case (alu_op_i)
			ALU_ADD:   result_o = src1_i + src2_i;
			ALU_SUB:   result_o = src1_i - src2_i;
			ALU_SLL:   result_o = src1_i << shamt;
			// compares give 0 or 1
			ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			ALU_XOR:   result_o = src1_i ^ src2_i;
			ALU_SRL:   result_o = src1_i >> shamt;
			// arithmetic shift keeps the sign bit
			ALU_SRA:   result_o = $unsigned($signed(src1_i) >>> shamt);
			ALU_OR:    result_o = src1_i | src2_i;
			ALU_AND:   result_o = src1_i & src2_i;
			ALU_PASS2: result_o = src2_i;
			// unused codes
			default:   result_o = '0;
		endcase
	end

endmodule

//--- src/exe_stage.sv
// execute stage that picks the two ALU operands and passes the writeback target along
`timescale 1ns/1ps

module exe_stage import exe_pkg::*; (
	input  logic [XLEN-1:0]        reg1_i,
	input  logic [XLEN-1:0]        reg2_i,
	input  logic [XLEN-1:0]        pc_i,
	input  logic [XLEN-1:0]        imm_i,
	input  logic [ALU_OP_W-1:0]    alu_op_i,
	input  logic [SEL_W-1:0]       alu_sel_i,
	input  logic                   wd_i,
	input  logic [REG_ADDR_W-1:0]  wreg_i,
	output logic                   wd_o,
	output logic [REG_ADDR_W-1:0]  wreg_o,
	output logic [XLEN-1:0]        wdata_o
);

	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;

	// write target goes straight through
	assign wd_o   = wd_i;
	assign wreg_o = wreg_i;

	// source 1 from low select bits
	always_comb begin
		case (alu_sel_i[1:0])
			SEL1_REG1: src1 = reg1_i;
			SEL1_PC:   src1 = pc_i;
			default:   src1 = '0;
		endcase
	end

	// source 2 from high select bits, four for link values
	always_comb begin
		case (alu_sel_i[3:2])
			SEL2_REG2: src2 = reg2_i;
			SEL2_IMM:  src2 = imm_i;
			SEL2_FOUR: src2 = XLEN'(4);
			default:   src2 = '0;
		endcase
	end

	alu u_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.alu_op_i (alu_op_i),
		.result_o (wdata_o)
	);

endmodule

//--- src/exe_core.sv
// top of the RV32I execute slice, one instruction per cycle in and a registered writeback report out
`timescale 1ns/1ps

module exe_core import exe_pkg::*; (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  logic                   inst_valid_i,
	input  logic [XLEN-1:0]        inst_i,
	input  logic [XLEN-1:0]        pc_i,
	output logic                   wb_valid_o,
	output logic [REG_ADDR_W-1:0]  wb_reg_o,
	output logic [XLEN-1:0]        wb_data_o
);

	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [XLEN-1:0]       imm;
	logic [ALU_OP_W-1:0]   alu_op;
	logic [SEL_W-1:0]      alu_sel;
	logic                  dec_wd;
	logic [REG_ADDR_W-1:0] dec_wreg;
	logic [XLEN-1:0]       reg1;
	logic [XLEN-1:0]       reg2;
	logic                  ex_wd;
	logic [REG_ADDR_W-1:0] ex_wreg;
	logic [XLEN-1:0]       ex_wdata;
	logic                  wr_en;

	inst_decode u_decode (
		.inst_i     (inst_i),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.imm_o      (imm),
		.alu_op_o   (alu_op),
		.alu_sel_o  (alu_sel),
		.wd_o       (dec_wd),
		.wreg_o     (dec_wreg)
	);

	// written at the issue edge, so the next issue sees it without forwarding
	reg_file u_regs (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.we_i       (wr_en),
		.waddr_i    (ex_wreg),
		.wdata_i    (ex_wdata),
		.rs1_data_o (reg1),
		.rs2_data_o (reg2)
	);

	exe_stage u_exe (
		.reg1_i    (reg1),
		.reg2_i    (reg2),
		.pc_i      (pc_i),
		.imm_i     (imm),
		.alu_op_i  (alu_op),
		.alu_sel_i (alu_sel),
		.wd_i      (dec_wd),
		.wreg_i    (dec_wreg),
		.wd_o      (ex_wd),
		.wreg_o    (ex_wreg),
		.wdata_o   (ex_wdata)
	);

	// no write without a valid issue or to x0
	assign wr_en = inst_valid_i && ex_wd && (ex_wreg != '0);

	// writeback report, one cycle pulse
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= wr_en;
		end
	end

	// payload only
	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			wb_reg_o  <= ex_wreg;
			wb_data_o <= ex_wdata;
		end
	end

	// reset leaves no stale writeback pulse
	assert property (@(posedge clk_i) reset_i |=> !wb_valid_o)
		else $error("wb_valid_o high right after reset");

endmodule

//--- testbench/tb_clock_gen.sv
// clock and reset source for the execute slice testbench, 8 ns period, reset held for 10 cycles
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	localparam real HALF_PERIOD  = 4.0;
	localparam int  RESET_CYCLES = 10;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	// synchronous release on a rising edge
	initial begin
		reset_o <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

//--- testbench/exe_core_tb.sv
// self-checking testbench for exe_core, top module of the simulation build in vlog.f
`timescale 1ns/1ps

module exe_core_tb import exe_pkg::*; ();

	localparam int         WB_WINDOW     = 4;
	localparam int         RESET_TIMEOUT = 20;
	localparam int         N_RAND        = 32;
	localparam logic [6:0] OPC_STORE     = 7'b0100011;

	typedef struct {
		string       name;
		logic [31:0] inst;
		logic [31:0] pc;
		logic        we;
		logic [4:0]  rd;
		logic [31:0] data;
	} vec_t;

	logic        clk;
	logic        reset;
	logic        inst_valid;
	logic [31:0] inst_word;
	logic [31:0] pc;
	logic        wb_valid;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;

	vec_t        vecs[$];
	// architectural register model
	logic [31:0] model_regs [NUM_REGS];
	logic        burst_we [N_RAND];
	logic [4:0]  burst_rd [N_RAND];
	logic [31:0] burst_data [N_RAND];
	logic [31:0] lfsr_state;
	int          n_run;
	int          n_pass;
	int          n_fail;

	tb_clock_gen clk_gen (
		.clk_o   (clk),
		.reset_o (reset)
	);

	exe_core dut (
		.clk_i        (clk),
		.reset_i      (reset),
		.inst_valid_i (inst_valid),
		.inst_i       (inst_word),
		.pc_i         (pc),
		.wb_valid_o   (wb_valid),
		.wb_reg_o     (wb_reg),
		.wb_data_o    (wb_data)
	);

	// instruction assembly per format
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	// fibonacci taps 32 22 2 1
	// new bit enters at bit 0
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	// RV32I result by funct3
	// alt marks sub or sra
	function automatic logic [31:0] ref_op(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			F3_ADD:  r = alt ? a - b : a + b;
			F3_SLL:  r = a << b[4:0];
			F3_SLT:  r = {31'b0, $signed(a) < $signed(b)};
			F3_SLTU: r = {31'b0, a < b};
			F3_XOR:  r = a ^ b;
			F3_SR: begin
				if (alt) r = $signed(a) >>> b[4:0];
				else r = a >> b[4:0];
			end
			F3_OR:   r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic add_vec(input string name, input logic [31:0] inst, input logic [31:0] pc_v,
		input logic we, input logic [4:0] rd, input logic [31:0] data);
		vec_t v;
		v = '{name, inst, pc_v, we, rd, data};
		vecs.push_back(v);
	endtask

	task automatic build_vectors();
		// immediates and sign extension
		add_vec("addi_pos", enc_i(12'd100, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM), '0, 1'b1, 5'd1, 32'h64);
		add_vec("addi_neg", enc_i(12'hff9, 5'd0, F3_ADD, 5'd2, OPC_OP_IMM), '0, 1'b1, 5'd2,
			32'hffff_fff9);
		add_vec("xori", enc_i(12'h0f0, 5'd1, F3_XOR, 5'd3, OPC_OP_IMM), '0, 1'b1, 5'd3, 32'h94);
		add_vec("ori_neg", enc_i(12'hf00, 5'd1, F3_OR, 5'd4, OPC_OP_IMM), '0, 1'b1, 5'd4,
			32'hffff_ff64);
		add_vec("andi", enc_i(12'h7f0, 5'd2, F3_AND, 5'd5, OPC_OP_IMM), '0, 1'b1, 5'd5, 32'h7f0);
		// register ops on x1 = 100 and x2 = -7
		add_vec("add", enc_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd6, OPC_OP), '0, 1'b1, 5'd6, 32'h5d);
		add_vec("sub", enc_r(7'h20, 5'd2, 5'd1, F3_ADD, 5'd7, OPC_OP), '0, 1'b1, 5'd7, 32'h6b);
		// shift amount 20 from x3
		add_vec("sll", enc_r(7'h00, 5'd3, 5'd1, F3_SLL, 5'd8, OPC_OP), '0, 1'b1, 5'd8,
			32'h0640_0000);
		add_vec("slt_neg", enc_r(7'h00, 5'd1, 5'd2, F3_SLT, 5'd9, OPC_OP), '0, 1'b1, 5'd9, 32'h1);
		add_vec("sltu", enc_r(7'h00, 5'd1, 5'd2, F3_SLTU, 5'd10, OPC_OP), '0, 1'b1, 5'd10, 32'h0);
		add_vec("xor", enc_r(7'h00, 5'd2, 5'd1, F3_XOR, 5'd11, OPC_OP), '0, 1'b1, 5'd11,
			32'hffff_ff9d);
		// shift amount 16 from x5
		add_vec("srl", enc_r(7'h00, 5'd5, 5'd2, F3_SR, 5'd12, OPC_OP), '0, 1'b1, 5'd12,
			32'h0000_ffff);
		add_vec("sra_neg", enc_r(7'h20, 5'd5, 5'd2, F3_SR, 5'd13, OPC_OP), '0, 1'b1, 5'd13,
			32'hffff_ffff);
		add_vec("or", enc_r(7'h00, 5'd2, 5'd1, F3_OR, 5'd14, OPC_OP), '0, 1'b1, 5'd14,
			32'hffff_fffd);
		add_vec("and", enc_r(7'h00, 5'd2, 5'd1, F3_AND, 5'd15, OPC_OP), '0, 1'b1, 5'd15, 32'h60);
		add_vec("srai", enc_i(12'h401, 5'd2, F3_SR, 5'd16, OPC_OP_IMM), '0, 1'b1, 5'd16,
			32'hffff_fffc);
		// upper immediates and link values
		add_vec("lui", enc_u(20'habcde, 5'd17, OPC_LUI), '0, 1'b1, 5'd17, 32'habcd_e000);
		add_vec("auipc", enc_u(20'h00012, 5'd18, OPC_AUIPC), 32'h1000, 1'b1, 5'd18, 32'h13000);
		add_vec("jal", enc_u(20'h12345, 5'd19, OPC_JAL), 32'h2000, 1'b1, 5'd19, 32'h2004);
		add_vec("jalr", enc_i(12'h010, 5'd1, 3'b000, 5'd20, OPC_JALR), 32'h3000c, 1'b1, 5'd20,
			32'h30010);
		// x0 ignores writes and reads as zero
		add_vec("addi_x0", enc_i(12'd5, 5'd1, F3_ADD, 5'd0, OPC_OP_IMM), '0, 1'b0, 5'd0, '0);
		add_vec("read_x0", enc_r(7'h00, 5'd1, 5'd0, F3_ADD, 5'd21, OPC_OP), '0, 1'b1, 5'd21, 32'h64);
		add_vec("store", enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd3, OPC_STORE), '0, 1'b0, 5'd0, '0);
	endtask

	// first pulse within the window sampled mid cycle
	task automatic wait_wb(output logic seen, output logic [4:0] rd, output logic [31:0] data);
		seen = 1'b0;
		rd = '0;
		data = '0;
		for (int n = 0; n < WB_WINDOW && !seen; n++) begin
			@(negedge clk);
			if (wb_valid) begin
				seen = 1'b1;
				rd = wb_reg;
				data = wb_data;
			end
		end
	endtask

	task automatic check_wb(input string name, input logic exp_we, input logic [4:0] exp_rd,
		input logic [31:0] exp_data, input logic seen, input logic [4:0] got_rd,
		input logic [31:0] got_data);
		int bad;
		bad = 0;
		assert (seen == exp_we) else begin
			$display("%s: writeback pulse %s", name,
				exp_we ? "did not arrive in time" : "appeared for a no-write instruction");
			bad++;
		end
		if (exp_we && seen) begin
			assert (got_rd == exp_rd) else begin
				$display("mismatch %s wb_reg expected %0d actual %0d", name, exp_rd, got_rd);
				bad++;
			end
			assert (got_data == exp_data) else begin
				$display("mismatch %s wb_data expected %h actual %h", name, exp_data, got_data);
				bad++;
			end
		end
		n_run++;
		if (bad == 0) begin
			n_pass++;
			$display("pass %s", name);
		end else begin
			n_fail++;
			$display("fail %s", name);
		end
	endtask

	// random ops on x0..x7 issued every cycle
	// source 1 is always the previous destination
	task automatic run_burst();
		logic [1:0]  kind;
		logic [2:0]  f3;
		logic        alt;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [6:0]  f7;
		logic [31:0] word;
		logic [31:0] expv;
		for (int k = 0; k <= N_RAND; k++) begin
			@(posedge clk);
			if (k < N_RAND) begin
				kind = 2'(draw_bits(2));
				f3 = 3'(draw_bits(3));
				alt = 1'(draw_bits(1));
				rd = {2'b00, 3'(draw_bits(3))};
				rs1 = {2'b00, 3'(draw_bits(3))};
				rs2 = {2'b00, 3'(draw_bits(3))};
				imm = 12'(draw_bits(12));
				if (k > 0)
					rs1 = burst_rd[k - 1];
				if (kind == 2'd3) begin
					word = enc_u({imm, f3, rs2[2:0], rs1[1:0]}, rd, OPC_LUI);
					expv = {imm, f3, rs2[2:0], rs1[1:0], 12'b0};
				end else if (kind == 2'd2) begin
					// shifts carry shamt and the sra bit in the immediate
					if (f3 == F3_SLL || f3 == F3_SR)
						imm = {1'b0, alt && (f3 == F3_SR), 5'b00000, imm[4:0]};
					word = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
					expv = ref_op(f3, (f3 == F3_SR) && imm[10], model_regs[rs1],
						{{20{imm[11]}}, imm});
				end else begin
					f7 = (alt && (f3 == F3_ADD || f3 == F3_SR)) ? 7'h20 : 7'h00;
					word = enc_r(f7, rs2, rs1, f3, rd, OPC_OP);
					expv = ref_op(f3, f7[5], model_regs[rs1], model_regs[rs2]);
				end
				burst_we[k] = (rd != '0);
				burst_rd[k] = rd;
				burst_data[k] = expv;
				if (burst_we[k])
					model_regs[rd] = expv;
				inst_valid <= 1'b1;
				inst_word <= word;
				pc <= 32'h4000;
			end else begin
				inst_valid <= 1'b0;
			end
			// pulse of the previous issue after one cycle
			if (k > 0) begin
				@(negedge clk);
				check_wb($sformatf("b2b_rand_%0d", k - 1), burst_we[k - 1], burst_rd[k - 1],
					burst_data[k - 1], wb_valid, wb_reg, wb_data);
			end
		end
	endtask

	initial begin
		logic        seen;
		logic [4:0]  got_rd;
		logic [31:0] got_data;
		int          n;
		inst_valid <= 1'b0;
		inst_word <= '0;
		pc <= '0;
		lfsr_state = 32'h43e4_fc6e;
		n_run = 0;
		n_pass = 0;
		n_fail = 0;
		for (int r = 0; r < NUM_REGS; r++)
			model_regs[r] = '0;
		build_vectors();

		@(posedge clk);
		n = 0;
		while (reset && n < RESET_TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (reset) begin
			$display("reset still asserted after %0d cycles", RESET_TIMEOUT);
			n_fail++;
		end else begin
			foreach (vecs[i]) begin
				@(posedge clk);
				inst_valid <= 1'b1;
				inst_word <= vecs[i].inst;
				pc <= vecs[i].pc;
				// issue edge
				@(posedge clk);
				inst_valid <= 1'b0;
				wait_wb(seen, got_rd, got_data);
				check_wb(vecs[i].name, vecs[i].we, vecs[i].rd, vecs[i].data, seen, got_rd,
					got_data);
				if (vecs[i].we)
					model_regs[vecs[i].rd] = vecs[i].data;
			end
			run_burst();
		end

		$display("tests run %0d, passed %0d, failed %0d", n_run, n_pass, n_fail);
		if (n_fail == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- vlog.f
src/exe_pkg.sv
src/inst_decode.sv
src/reg_file.sv
src/alu.sv
src/exe_stage.sv
src/exe_core.sv
testbench/tb_clock_gen.sv
testbench/exe_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exe_core_tb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
